// File: hdl/decode_stage.sv
//----------------------------------------
// Decode: control, load-use stall, ID/EX
// Hold is combinational from the ID/EX
// register and the word in decode
// Unknown opcodes and functions are nops
//----------------------------------------
`timescale 1ns/1ps

module decode_stage
	import mips_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  if_id_t    if_id,
	input  redirect_t redirect,
	input  wb_t       wb,
	output logic      hold,
	output id_ex_t    id_ex
);

	instr_u      instr;
	ctrl_t       ctrl;
	logic [31:0] data_1;
	logic [31:0] data_2;
	logic [31:0] imm_ext;
	id_ex_t      id_ex_next;

	assign instr = if_id.instr;

	reg_file reg_file_i (
		.clk    (clk),
		.rst_n  (rst_n),
		.rs_idx (instr.r_fmt.rs),
		.rt_idx (instr.r_fmt.rt),
		.wb     (wb),
		.data_1 (data_1),
		.data_2 (data_2)
	);

	// ---------------------------------------
	// Control decode
	// ---------------------------------------
	always_comb
	begin
		ctrl = '0;
		case (instr.r_fmt.opcode)
			op_rtype:
			begin
				ctrl.reg_write  = 1'b1;
				ctrl.reg_dst_rd = 1'b1;
				case (instr.r_fmt.funct)
					fn_add: ctrl.alu_op = alu_add;
					fn_sub: ctrl.alu_op = alu_sub;
					fn_and: ctrl.alu_op = alu_and;
					fn_or:  ctrl.alu_op = alu_or;
					fn_slt: ctrl.alu_op = alu_slt;
					// Unsupported function, no write
					default: ctrl = '0;
				endcase
			end
			op_lw:
			begin
				ctrl.reg_write   = 1'b1;
				ctrl.mem_read    = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op      = alu_add;
			end
			op_sw:
			begin
				ctrl.mem_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op      = alu_add;
			end
			// Compare happens in execute
			op_beq:
			begin
				ctrl.branch = 1'b1;
				ctrl.alu_op = alu_sub;
			end
			default: ctrl = '0;
		endcase
	end

	// Sign-extended immediate
	assign imm_ext = {{16{instr.i_fmt.imm[15]}}, instr.i_fmt.imm};

	// Load in execute feeding the word in decode
	assign hold = id_ex.valid && id_ex.ctrl.mem_read && (id_ex.rt != 5'd0) &&
		((id_ex.rt == instr.r_fmt.rs) || (id_ex.rt == instr.r_fmt.rt));

	always_comb
	begin
		id_ex_next.valid    = if_id.valid;
		id_ex_next.ctrl     = ctrl;
		id_ex_next.pc_plus4 = if_id.pc_plus4;
		id_ex_next.rs       = instr.r_fmt.rs;
		id_ex_next.rt       = instr.r_fmt.rt;
		id_ex_next.rd       = instr.r_fmt.rd;
		id_ex_next.data_1   = data_1;
		id_ex_next.data_2   = data_2;
		id_ex_next.imm      = imm_ext;
	end

	// ID/EX register, bubble on stall or squash
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			id_ex <= '0;
		else if (redirect.taken || hold)
			id_ex.valid <= 1'b0;
		else
			id_ex <= id_ex_next;
	end

endmodule

// File: hdl/execute_stage.sv
//----------------------------------------
// Execute: forwarding, ALU, beq resolve
// Forwarding covers EX/MEM and writeback
// A load result in EX/MEM is never
// forwarded; decode stalls for it
//----------------------------------------
`timescale 1ns/1ps

module execute_stage
	import mips_pkg::*;
(
	input  logic      clk,
	input  logic      rst_n,
	input  id_ex_t    id_ex,
	input  wb_t       wb,
	output redirect_t redirect,
	output ex_mem_t   ex_mem
);

	logic [31:0] op_a;
	logic [31:0] op_fwd_b;
	logic [31:0] op_b;
	logic [31:0] alu_result;
	logic [4:0]  dest;

	// Newest producer wins, r0 never forwarded
	function automatic logic [31:0] fwd_sel(
		input logic [4:0]  idx,
		input logic [31:0] rf_val,
		input ex_mem_t     mem_src,
		input wb_t         wb_src
	);
		logic [31:0] val;
		val = rf_val;
		if (idx != 5'd0)
		begin
			if (mem_src.valid && mem_src.reg_write && mem_src.dest == idx)
				val = mem_src.alu_result;
			else if (wb_src.valid && wb_src.reg_write && wb_src.dest == idx)
				val = wb_src.data;
		end
		return val;
	endfunction

	assign op_a     = fwd_sel(id_ex.rs, id_ex.data_1, ex_mem, wb);
	assign op_fwd_b = fwd_sel(id_ex.rt, id_ex.data_2, ex_mem, wb);
	assign op_b     = id_ex.ctrl.alu_src_imm ? id_ex.imm : op_fwd_b;

	// ---------------------------------------
	// ALU
	// ---------------------------------------
	always_comb
	begin
		case (id_ex.ctrl.alu_op)
			alu_add: alu_result = op_a + op_b;
			alu_sub: alu_result = op_a - op_b;
			alu_and: alu_result = op_a & op_b;
			alu_or:  alu_result = op_a | op_b;
			// Signed compare
			alu_slt: alu_result = {31'd0, $signed(op_a) < $signed(op_b)};
			default: alu_result = '0;
		endcase
	end

	// Branch taken when forwarded operands match
	assign redirect.taken  = id_ex.valid && id_ex.ctrl.branch && (op_a == op_fwd_b);
	assign redirect.target = id_ex.pc_plus4 + {id_ex.imm[29:0], 2'b00};

	// rd for R-type, rt for lw
	assign dest = id_ex.ctrl.reg_dst_rd ? id_ex.rd : id_ex.rt;

	// EX/MEM register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			ex_mem <= '0;
		else
		begin
			ex_mem.valid      <= id_ex.valid;
			ex_mem.reg_write  <= id_ex.ctrl.reg_write;
			ex_mem.mem_read   <= id_ex.ctrl.mem_read;
			ex_mem.mem_write  <= id_ex.ctrl.mem_write;
			ex_mem.dest       <= dest;
			ex_mem.alu_result <= alu_result;
			ex_mem.store_data <= op_fwd_b;
		end
	end

endmodule

// File: hdl/fetch_stage.sv
//----------------------------------------
// Program counter and IF/ID register
// imem_data must arrive in the same cycle
// Redirect takes priority over hold
//----------------------------------------
`timescale 1ns/1ps

module fetch_stage
	import mips_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        hold,
	input  redirect_t   redirect,
	input  logic [31:0] imem_data,
	output logic [31:0] imem_addr,
	output if_id_t      if_id
);

	logic [31:0] pc;
	logic [31:0] pc_plus4;

	assign pc_plus4  = pc + 32'd4;
	assign imem_addr = pc;

	// Next fetch address
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pc <= reset_pc;
		else if (redirect.taken)
			pc <= redirect.target;
		else if (!hold)
			pc <= pc_plus4;
	end

	// IF/ID register, squashed on a taken branch
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			if_id <= '0;
		else if (redirect.taken)
			if_id.valid <= 1'b0;
		else if (!hold)
			if_id <= '{valid: 1'b1, pc_plus4: pc_plus4, instr: imem_data};
	end

endmodule

// File: hdl/memory_stage.sv
//----------------------------------------
// Memory access and MEM/WB register
// Data memory answers loads in the same
// cycle; stores land on the next edge
//----------------------------------------
`timescale 1ns/1ps

module memory_stage
	import mips_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  ex_mem_t     ex_mem,
	input  logic [31:0] dmem_rdata,
	output logic [31:0] dmem_addr,
	output logic [31:0] dmem_wdata,
	output logic        dmem_we,
	output wb_t         wb
);

	logic [31:0] result;

	// Data port straight from EX/MEM
	assign dmem_addr  = ex_mem.alu_result;
	assign dmem_wdata = ex_mem.store_data;
	assign dmem_we    = ex_mem.valid && ex_mem.mem_write;

	// Load data or ALU value
	assign result = ex_mem.mem_read ? dmem_rdata : ex_mem.alu_result;

	// Writeback stage register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			wb <= '0;
		else
		begin
			wb.valid     <= ex_mem.valid;
			wb.reg_write <= ex_mem.reg_write;
			wb.dest      <= ex_mem.dest;
			wb.data      <= result;
		end
	end

endmodule

// File: hdl/mips_pipe.sv
//----------------------------------------
// Five-stage pipeline top level
// Both memories live outside the core and
// must answer in the same cycle
// No wait states and no back-pressure
//----------------------------------------
`timescale 1ns/1ps

module mips_pipe
	import mips_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	// Fetch port
	output logic [31:0] imem_addr,
	input  logic [31:0] imem_data,
	// Data port
	output logic [31:0] dmem_addr,
	output logic [31:0] dmem_wdata,
	output logic        dmem_we,
	input  logic [31:0] dmem_rdata
);

	// Stage links
	if_id_t    if_id;
	id_ex_t    id_ex;
	ex_mem_t   ex_mem;
	wb_t       wb;
	redirect_t redirect;
	logic      hold;

	fetch_stage fetch_stage_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.hold      (hold),
		.redirect  (redirect),
		.imem_data (imem_data),
		.imem_addr (imem_addr),
		.if_id     (if_id)
	);

	decode_stage decode_stage_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.if_id    (if_id),
		.redirect (redirect),
		.wb       (wb),
		.hold     (hold),
		.id_ex    (id_ex)
	);

	execute_stage execute_stage_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.id_ex    (id_ex),
		.wb       (wb),
		.redirect (redirect),
		.ex_mem   (ex_mem)
	);

	memory_stage memory_stage_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.ex_mem     (ex_mem),
		.dmem_rdata (dmem_rdata),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.wb         (wb)
	);

endmodule

// File: hdl/mips_pkg.sv
//----------------------------------------
// Shared types for the five-stage core
// Integer subset only: add sub and or slt,
// lw, sw and beq; other opcodes act as nop
// Word addressing is left to the memories
//----------------------------------------

package mips_pkg;

	// Primary opcodes
	localparam logic [5:0] op_rtype = 6'b000000;
	localparam logic [5:0] op_lw    = 6'b100011;
	localparam logic [5:0] op_sw    = 6'b101011;
	localparam logic [5:0] op_beq   = 6'b000100;

	// R-type function codes
	localparam logic [5:0] fn_add = 6'b100000;
	localparam logic [5:0] fn_sub = 6'b100010;
	localparam logic [5:0] fn_and = 6'b100100;
	localparam logic [5:0] fn_or  = 6'b100101;
	localparam logic [5:0] fn_slt = 6'b101010;

	// First fetch address after reset
	localparam logic [31:0] reset_pc = 32'h0000_0000;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_slt
	} alu_op_e;

	// ---------------------------------------
	// Instruction word, two views
	// ---------------------------------------
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
	} instr_u;

	// ---------------------------------------
	// Stage buses
	// ---------------------------------------
	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    alu_src_imm;
		logic    reg_dst_rd;
		logic    branch;
		alu_op_e alu_op;
	} ctrl_t;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc_plus4;
		instr_u      instr;
	} if_id_t;

	typedef struct packed {
		logic        valid;
		ctrl_t       ctrl;
		logic [31:0] pc_plus4;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [31:0] data_1;
		logic [31:0] data_2;
		logic [31:0] imm;
	} id_ex_t;

	typedef struct packed {
		logic        taken;
		logic [31:0] target;
	} redirect_t;

	typedef struct packed {
		logic        valid;
		logic        reg_write;
		logic        mem_read;
		logic        mem_write;
		logic [4:0]  dest;
		logic [31:0] alu_result;
		logic [31:0] store_data;
	} ex_mem_t;

	// Result of the writeback stage
	typedef struct packed {
		logic        valid;
		logic        reg_write;
		logic [4:0]  dest;
		logic [31:0] data;
	} wb_t;

endpackage

// File: hdl/reg_file.sv
//----------------------------------------
// 32 x 32 register file, r0 reads zero
// Combinational reads with write-through
// from the writeback bus
//----------------------------------------
`timescale 1ns/1ps

module reg_file
	import mips_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic [4:0]  rs_idx,
	input  logic [4:0]  rt_idx,
	input  wb_t         wb,
	output logic [31:0] data_1,
	output logic [31:0] data_2
);

	// r0 is not stored
	logic [31:0] regs [1:31];
	logic        wr_en;

	assign wr_en = wb.valid && wb.reg_write && (wb.dest != 5'd0);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
			regs[wb.dest] <= wb.data;
	end

	// Same-cycle write seen by the reader
	assign data_1 = (rs_idx == 5'd0) ? 32'd0 :
		(wr_en && wb.dest == rs_idx) ? wb.data : regs[rs_idx];
	assign data_2 = (rt_idx == 5'd0) ? 32'd0 :
		(wr_en && wb.dest == rt_idx) ? wb.data : regs[rt_idx];

endmodule

// File: mips_pipe.f
hdl/mips_pkg.sv
hdl/fetch_stage.sv
hdl/reg_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/mips_pipe.sv
+incdir+test
test/tb_mips_pipe.sv

// File: test/tb_programs.svh
//----------------------------------------
// Programs and sequential store model
// Included inside the testbench module
// Every program ends in beq r0, r0 to
// itself, which also stops the model
//----------------------------------------
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Whole-address fill, always word aligned
function automatic logic [31:0] fill_word(input logic [31:0] addr);
	return (addr * 32'h9e37_79b1) ^ 32'hc3a5_0f0c;
endfunction

function automatic logic [31:0] r_word(input logic [5:0] funct,
	input logic [4:0] rd, input logic [4:0] rs, input logic [4:0] rt);
	return {op_rtype, rs, rt, rd, 5'd0, funct};
endfunction

function automatic logic [31:0] i_word(input logic [5:0] op,
	input logic [4:0] rt, input logic [4:0] rs, input logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

task automatic emit(input logic [31:0] word);
	imem[prog_len] = word;
	prog_len++;
endtask

task automatic clear_program();
	for (int i = 0; i < 256; i++)
		imem[i] = 32'd0;
	prog_len = 0;
endtask

// All five ALU ops, back to back, negative slt operands
task automatic build_arith();
	clear_program();
	emit(i_word(op_lw, 5'd1, 5'd0, 16'h0000));
	emit(i_word(op_lw, 5'd2, 5'd0, 16'h0004));
	emit(r_word(fn_sub, 5'd3, 5'd0, 5'd1));
	emit(r_word(fn_sub, 5'd4, 5'd0, 5'd2));
	emit(r_word(fn_slt, 5'd5, 5'd3, 5'd4));
	emit(r_word(fn_slt, 5'd6, 5'd4, 5'd3));
	emit(r_word(fn_slt, 5'd7, 5'd3, 5'd1));
	emit(r_word(fn_add, 5'd8, 5'd5, 5'd6));
	emit(r_word(fn_and, 5'd9, 5'd1, 5'd2));
	emit(r_word(fn_or, 5'd10, 5'd9, 5'd3));
	emit(r_word(fn_add, 5'd11, 5'd10, 5'd8));
	// Store data straight from the producer
	emit(i_word(op_sw, 5'd11, 5'd0, 16'h0040));
	for (int r = 3; r <= 10; r++)
		emit(i_word(op_sw, 5'(r), 5'd0, 16'(16'h0040 + 4 * r)));
	emit(i_word(op_beq, 5'd0, 5'd0, 16'hffff));
endtask

task automatic build_load_use();
	clear_program();
	// Fetch two words past the load repeats
	stall_addr_exp = prog_len * 4 + 8;
	emit(i_word(op_lw, 5'd1, 5'd0, 16'h0008));
	emit(r_word(fn_add, 5'd2, 5'd1, 5'd1));
	emit(i_word(op_sw, 5'd2, 5'd0, 16'h0080));
	emit(i_word(op_beq, 5'd0, 5'd0, 16'hffff));
endtask

// Taken and not-taken beq, then a three-pass loop
task automatic build_branch();
	clear_program();
	emit(i_word(op_lw, 5'd1, 5'd0, 16'h0000));
	emit(i_word(op_lw, 5'd2, 5'd0, 16'h0000));
	emit(i_word(op_beq, 5'd2, 5'd1, 16'h0002));
	emit(i_word(op_sw, 5'd1, 5'd0, 16'h0090));
	emit(i_word(op_sw, 5'd2, 5'd0, 16'h0094));
	emit(i_word(op_lw, 5'd3, 5'd0, 16'h0004));
	emit(i_word(op_beq, 5'd3, 5'd1, 16'h0002));
	emit(i_word(op_sw, 5'd1, 5'd0, 16'h0098));
	emit(i_word(op_sw, 5'd3, 5'd0, 16'h009c));
	// r6 = 1 and r7 = 3 without immediates
	emit(r_word(fn_slt, 5'd5, 5'd1, 5'd3));
	emit(r_word(fn_slt, 5'd6, 5'd3, 5'd1));
	emit(r_word(fn_add, 5'd6, 5'd5, 5'd6));
	emit(r_word(fn_add, 5'd7, 5'd6, 5'd6));
	emit(r_word(fn_add, 5'd7, 5'd7, 5'd6));
	emit(r_word(fn_add, 5'd8, 5'd0, 5'd0));
	emit(r_word(fn_add, 5'd8, 5'd8, 5'd1));
	emit(r_word(fn_sub, 5'd7, 5'd7, 5'd6));
	emit(i_word(op_beq, 5'd0, 5'd7, 16'h0001));
	emit(i_word(op_beq, 5'd0, 5'd0, 16'hfffc));
	emit(i_word(op_sw, 5'd8, 5'd0, 16'h00a0));
	emit(i_word(op_beq, 5'd0, 5'd0, 16'hffff));
endtask

// r1 is the load/store base and is never a destination
task automatic build_random(input int count);
	logic [5:0] functs [0:4] = '{fn_add, fn_sub, fn_and, fn_or, fn_slt};
	logic [4:0]  rd;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [15:0] imm;
	int          kind;
	clear_program();
	emit(i_word(op_lw, 5'd1, 5'd0, 16'h03fc));
	for (int k = 0; k < count; k++)
	begin
		kind = $urandom_range(0, 5);
		rd   = 5'($urandom_range(2, 7));
		rs   = 5'($urandom_range(0, 7));
		rt   = 5'($urandom_range(0, 7));
		imm  = 16'($urandom_range(0, 255) * 4);
		if (kind <= 2)
			emit(r_word(functs[$urandom_range(0, 4)], rd, rs, rt));
		else if (kind <= 4)
			emit(i_word(op_lw, rd, 5'd1, imm));
		else
			emit(i_word(op_sw, rt, 5'd1, imm));
	end
	emit(i_word(op_beq, 5'd0, 5'd0, 16'hffff));
endtask

// ---------------------------------------
// Sequential model, ISA rules only
// ---------------------------------------
task automatic run_model();
	logic [31:0] regs [0:31];
	logic [31:0] mem [0:255];
	logic [31:0] pc;
	logic [31:0] next_pc;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] imm;
	logic [31:0] addr;
	instr_u      w;
	int          steps;
	bit          done;
	for (int i = 0; i < 32; i++)
		regs[i] = 32'd0;
	for (int i = 0; i < 256; i++)
		mem[i] = fill_word(i * 4);
	pc = reset_pc;
	steps = 0;
	done = 1'b0;
	while (!done && steps < 5000)
	begin
		w = imem[pc[9:2]];
		a = regs[w.r_fmt.rs];
		b = regs[w.r_fmt.rt];
		imm = {{16{w.i_fmt.imm[15]}}, w.i_fmt.imm};
		addr = a + imm;
		next_pc = pc + 32'd4;
		case (w.r_fmt.opcode)
			op_rtype:
			begin
				if (w.r_fmt.rd != 5'd0)
				begin
					case (w.r_fmt.funct)
						fn_add: regs[w.r_fmt.rd] = a + b;
						fn_sub: regs[w.r_fmt.rd] = a - b;
						fn_and: regs[w.r_fmt.rd] = a & b;
						fn_or:  regs[w.r_fmt.rd] = a | b;
						fn_slt: regs[w.r_fmt.rd] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: ;
					endcase
				end
			end
			op_lw:
			begin
				if (w.i_fmt.rt != 5'd0)
					regs[w.i_fmt.rt] = mem[addr[9:2]];
			end
			op_sw:
			begin
				exp_addr[exp_count] = addr;
				exp_data[exp_count] = b;
				exp_count++;
				mem[addr[9:2]] = b;
			end
			op_beq:
			begin
				if (a == b)
				begin
					next_pc = pc + 32'd4 + {imm[29:0], 2'b00};
					// Branch to itself ends the program
					done = (next_pc == pc);
				end
			end
			default: ;
		endcase
		pc = next_pc;
		steps++;
	end
	assert (done)
	else
	begin
		task_errors++;
		$display("Model ran %0d steps without reaching the final loop", steps);
	end
endtask

`endif

// File: test/tb_mips_pipe.sv
//----------------------------------------
// Testbench for the five-stage core
// Both memories hold 256 words indexed by
// address bits 9:2 and higher bits wrap
// Stores are compared in program order
// with a sequential model of each program
//----------------------------------------
`timescale 1ns/1ps

module tb_mips_pipe
	import mips_pkg::*;
();

	logic        clk;
	logic        rst_n;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic [31:0] dmem_addr;
	logic [31:0] dmem_wdata;
	logic        dmem_we;
	logic [31:0] dmem_rdata;

	// Memory models
	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	int          prog_len;

	// Expected stores from the model in program order
	logic [31:0] exp_addr [0:1023];
	logic [31:0] exp_data [0:1023];
	int          exp_count = 0;
	int          exp_ptr = 0;

	// Check and error counts
	int store_checks = 0;
	int store_errors = 0;
	int reset_checks = 0;
	int reset_errors = 0;
	int task_errors = 0;

	// Fetch address repeats from load-use stalls
	int          repeat_count = 0;
	logic [31:0] repeat_addr;
	logic [31:0] prev_addr;
	logic        prev_ok = 1'b0;
	logic [31:0] stall_addr_exp;

	// Watchdog state
	int          cycle_count = 0;
	int          budget = 0;
	int unsigned seed_val;

	`include "tb_programs.svh"

	mips_pipe mips_pipe_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_we    (dmem_we),
		.dmem_rdata (dmem_rdata)
	);

	// Both memories answer in the same cycle
	assign imem_data  = imem[imem_addr[9:2]];
	assign dmem_rdata = dmem[dmem_addr[9:2]];

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Data memory refilled on every reset cycle
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 256; i++)
				dmem[i] <= fill_word(i * 4);
		end
		else if (dmem_we)
			dmem[dmem_addr[9:2]] <= dmem_wdata;
	end

	// ---------------------------------------
	// Checkers
	// ---------------------------------------
	always @(posedge clk)
	begin
		if (!rst_n)
		begin
			reset_checks++;
			assert (imem_addr == 32'd0 && !dmem_we)
			else
			begin
				reset_errors++;
				$display("Error at %0t: in reset imem_addr %h dmem_we %b", $time, imem_addr,
					dmem_we);
			end
		end
	end

	// Each store pops the next model store
	always @(posedge clk)
	begin
		if (rst_n && dmem_we)
		begin
			store_checks++;
			assert (exp_ptr != exp_count)
			else
			begin
				store_errors++;
				$display("Error at %0t: unexpected store of %h to %h", $time, dmem_wdata,
					dmem_addr);
			end
			if (exp_ptr != exp_count)
			begin
				assert (dmem_addr == exp_addr[exp_ptr] && dmem_wdata == exp_data[exp_ptr])
				else
				begin
					store_errors++;
					$display("Error at %0t: store %h to %h, expected %h to %h", $time,
						dmem_wdata, dmem_addr, exp_data[exp_ptr], exp_addr[exp_ptr]);
				end
				exp_ptr <= exp_ptr + 1;
			end
		end
	end

	// Same fetch address on two edges in a row
	always @(posedge clk)
	begin
		if (rst_n && prev_ok && imem_addr == prev_addr)
		begin
			repeat_count <= repeat_count + 1;
			repeat_addr  <= imem_addr;
		end
		prev_addr <= imem_addr;
		prev_ok   <= rst_n;
	end

	task automatic print_counts();
		$display("Checks: %0d stores, %0d reset cycles; errors: %0d store, %0d reset, %0d other",
			store_checks, reset_checks, store_errors, reset_errors, task_errors);
	endtask

	// Budget grows by 40 cycles per loaded instruction
	always @(posedge clk)
	begin
		if (rst_n)
			cycle_count++;
		if (cycle_count > budget)
		begin
			$display("Watchdog expired after %0d cycles with %0d stores still outstanding",
				cycle_count, exp_count - exp_ptr);
			print_counts();
			$display("Result: FAILED");
			$finish;
		end
	end

	// ---------------------------------------
	// Test sequence
	// ---------------------------------------
	task automatic enter_reset();
		@(posedge clk);
		rst_n <= 1'b0;
	endtask

	task automatic run_loaded(input bit check_stall);
		int first_repeat;
		int waited;
		run_model();
		budget = budget + 40 * prog_len;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		first_repeat = repeat_count;
		// Stores of this program, bounded well inside the watchdog
		waited = 0;
		while (exp_ptr != exp_count && waited < 20 * prog_len)
		begin
			@(posedge clk);
			waited++;
		end
		// Room for squashed stores to show up
		repeat (12) @(posedge clk);
		assert (exp_ptr == exp_count)
		else
		begin
			task_errors++;
			$display("Error at %0t: %0d expected stores missing", $time, exp_count - exp_ptr);
		end
		if (check_stall)
		begin
			assert (repeat_count - first_repeat == 1 && repeat_addr == stall_addr_exp)
			else
			begin
				task_errors++;
				$display("Error at %0t: %0d fetch repeats, last at %h, expected one at %h",
					$time, repeat_count - first_repeat, repeat_addr, stall_addr_exp);
			end
		end
	endtask

	initial
	begin
		rst_n <= 1'b0;
		for (int i = 0; i < 256; i++)
			imem[i] = 32'd0;
		seed_val = $urandom(61);
		enter_reset();
		build_arith();
		run_loaded(1'b0);
		enter_reset();
		build_load_use();
		run_loaded(1'b1);
		enter_reset();
		build_branch();
		run_loaded(1'b0);
		enter_reset();
		build_random(200);
		run_loaded(1'b0);
		print_counts();
		if (store_errors + reset_errors + task_errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule
